/* common/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Words per memory command, must be even
`define DMA_BURST_LEN 16
// Words per operation group
`define DMA_CONV_BURST_LEN 16
`define DMA_POOL_BURST_LEN 1

// Stream buffer depth
`define DMA_FIFO_DEPTH 1024
// Byte address width
`define DMA_ADDR_W 30

// Memory model size in words and warm-up cycles
`define DMA_MEM_WORDS 1024
`define DMA_CALIB_CYCLES 20

`endif

/* common/dma_pkg.sv */
package dma_pkg;

	// Operation type held in the op_type register
	// Codes 6 and 7 are handled as pooling
	typedef enum logic [2:0] {
		OP_RAW   = 3'd0,
		OP_CONV1 = 3'd1,
		OP_CONV2 = 3'd2,
		OP_CONV3 = 3'd3,
		OP_POOL1 = 3'd4,
		OP_POOL2 = 3'd5
	} op_type_t;

	// Memory port command codes
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} mem_cmd_t;

endpackage

/* hdl/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                           clk,
	input  logic                           reset_d,
	input  logic                           we,
	input  logic [31:0]                    wdata,
	input  logic                           re,
	output logic [31:0]                    rdata,
	output logic                           rvalid,
	output logic [$clog2(DEPTH+1)-1:0]     count,
	output logic                           full,
	output logic                           empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [31:0]   mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_wr;
	logic          do_rd;

	assign full  = (count == DEPTH);
	assign empty = (count == 0);

	// Overflowing writes and underflowing reads are dropped
	assign do_wr = we && !full;
	assign do_rd = re && !empty;

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			rvalid <= 1'b0;
		end else begin
			rvalid <= do_rd;
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			rdata <= mem[rd_ptr];
	end

endmodule

/* dma/dma_regs.sv */
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_regs import dma_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_d,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [4:0]             wb_adr,
	input  logic [31:0]            wb_dat_w,
	output logic [31:0]            wb_dat_r,
	output logic                   wb_ack,
	input  logic                   calib_done,
	input  logic                   busy,
	output logic                   writes_en,
	output logic                   reads_en,
	output logic [`DMA_ADDR_W-1:0] start_addr,
	output logic                   addr_load,
	output logic [15:0]            op_num,
	output op_type_t               op_type
);

	logic req;

	// New request only while no ack is pending
	assign req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wb_ack     <= 1'b0;
			addr_load  <= 1'b0;
			writes_en  <= 1'b0;
			reads_en   <= 1'b0;
			start_addr <= '0;
			op_num     <= '0;
			op_type    <= OP_RAW;
		end else begin
			wb_ack    <= req;
			addr_load <= 1'b0;
			if (req && wb_we) begin
				case (wb_adr)
					5'h00: begin
						writes_en <= wb_dat_w[0];
						reads_en  <= wb_dat_w[1];
					end
					5'h04: begin
						start_addr <= wb_dat_w[`DMA_ADDR_W-1:0];
						addr_load  <= 1'b1;
					end
					5'h08: op_num  <= wb_dat_w[15:0];
					5'h0c: op_type <= op_type_t'(wb_dat_w[2:0]);
					default: ;
				endcase
			end
		end
	end

	// Read data is captured along with the ack
	always_ff @(posedge clk) begin
		if (req) begin
			case (wb_adr)
				5'h00: wb_dat_r <= {30'd0, reads_en, writes_en};
				5'h04: wb_dat_r <= 32'(start_addr);
				5'h08: wb_dat_r <= {16'd0, op_num};
				5'h0c: wb_dat_r <= {29'd0, op_type};
				5'h10: wb_dat_r <= {30'd0, busy, calib_done};
				default: wb_dat_r <= '0;
			endcase
		end
	end

endmodule

/* dma/dma_engine.sv */
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_engine import dma_pkg::*; (
	input  logic                                 clk,
	input  logic                                 reset_d,
	input  logic                                 writes_en,
	input  logic                                 reads_en,
	input  logic                                 calib_done,
	input  logic [`DMA_ADDR_W-1:0]               start_addr,
	input  logic                                 addr_load,
	input  logic [15:0]                          op_num,
	input  op_type_t                             op_type,
	// Input buffer
	output logic                                 ib_re,
	input  logic [31:0]                          ib_data,
	input  logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] ib_count,
	input  logic                                 ib_valid,
	// Output buffer
	output logic                                 ob_we,
	output logic [31:0]                          ob_data,
	input  logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0] ob_count,
	// Memory port
	output logic                                 cmd_en,
	output mem_cmd_t                             cmd_instr,
	output logic [`DMA_ADDR_W-1:0]               cmd_byte_addr,
	output logic [5:0]                           cmd_bl,
	input  logic                                 cmd_full,
	output logic                                 wr_en,
	output logic [31:0]                          wr_data,
	output logic [3:0]                           wr_mask,
	input  logic                                 wr_full,
	output logic                                 rd_en,
	input  logic [31:0]                          rd_data,
	input  logic                                 rd_empty,
	output logic                                 busy
);

	localparam int BL = `DMA_BURST_LEN;
	localparam int CNT_W = $clog2(BL + 1);
	localparam int OB_LIMIT = `DMA_FIFO_DEPTH - 1 - BL;
	localparam logic [15:0] CONV_STEP = 16'(BL / `DMA_CONV_BURST_LEN);
	localparam logic [15:0] POOL_STEP = 16'(BL / `DMA_POOL_BURST_LEN);
	localparam logic [`DMA_ADDR_W-1:0] ADDR_STEP = `DMA_ADDR_W'(4 * BL);

	localparam logic [2:0] S_IDLE    = 3'd0,
	                       S_WR_REQ  = 3'd1,
	                       S_WR_WAIT = 3'd2,
	                       S_WR_NEXT = 3'd3,
	                       S_RD_CMD  = 3'd4,
	                       S_RD_WAIT = 3'd5,
	                       S_RD_POP  = 3'd6,
	                       S_RD_TAKE = 3'd7;

	logic [2:0]            state;
	logic [2:0]            next_state;
	logic [CNT_W-1:0]      burst_cnt;
	logic [15:0]           op_count;
	logic [15:0]           op_step;
	logic                  ops_done;
	logic                  ops_hit;
	logic                  is_raw;
	logic                  ob_room;
	logic                  start_wr;
	logic                  start_rd;
	logic [`DMA_ADDR_W-1:0] wr_ptr;
	logic [`DMA_ADDR_W-1:0] rd_ptr;

	assign cmd_bl  = 6'(BL - 1);
	assign wr_mask = 4'b0000;
	assign busy    = (state != S_IDLE);

	assign is_raw  = (op_type == OP_RAW);
	assign op_step = (op_type inside {OP_CONV1, OP_CONV2, OP_CONV3}) ? CONV_STEP : POOL_STEP;
	// Word being taken now completes the programmed op count
	assign ops_hit = !is_raw && ({1'b0, op_count} + {1'b0, op_step} >= {1'b0, op_num});

	assign ob_room  = (ob_count < OB_LIMIT);
	assign start_wr = calib_done && writes_en && (ib_count >= BL);
	assign start_rd = calib_done && reads_en && ob_room;

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:
				if (start_wr)
					next_state = S_WR_REQ;
				else if (start_rd)
					next_state = S_RD_CMD;
			S_WR_REQ:
				if (!wr_full)
					next_state = S_WR_WAIT;
			S_WR_WAIT:
				if (ib_valid)
					next_state = S_WR_NEXT;
			S_WR_NEXT:
				if (burst_cnt != 0)
					next_state = S_WR_REQ;
				else if (!cmd_full)
					next_state = S_IDLE;
			// Continuation bursts also wait here for buffer room
			S_RD_CMD:
				if (ob_room && !cmd_full)
					next_state = S_RD_WAIT;
			S_RD_WAIT:
				if (!rd_empty)
					next_state = S_RD_POP;
			S_RD_POP:
				next_state = S_RD_TAKE;
			S_RD_TAKE:
				if (burst_cnt != 0)
					next_state = S_RD_WAIT;
				else if (is_raw || ops_done || ops_hit)
					next_state = S_IDLE;
				else
					next_state = S_RD_CMD;
			default:
				next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			state         <= S_IDLE;
			burst_cnt     <= '0;
			op_count      <= '0;
			ops_done      <= 1'b0;
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			ib_re         <= 1'b0;
			wr_en         <= 1'b0;
			rd_en         <= 1'b0;
			ob_we         <= 1'b0;
			cmd_en        <= 1'b0;
			cmd_instr     <= CMD_WRITE;
			cmd_byte_addr <= '0;
		end else begin
			state  <= next_state;
			ib_re  <= 1'b0;
			wr_en  <= 1'b0;
			rd_en  <= 1'b0;
			ob_we  <= 1'b0;
			cmd_en <= 1'b0;
			case (state)
				S_IDLE: begin
					burst_cnt <= CNT_W'(BL);
					op_count  <= '0;
					ops_done  <= 1'b0;
				end
				S_WR_REQ:
					if (!wr_full)
						ib_re <= 1'b1;
				S_WR_WAIT:
					if (ib_valid) begin
						wr_en     <= 1'b1;
						burst_cnt <= burst_cnt - 1'b1;
					end
				// Whole burst is queued before its command goes out
				S_WR_NEXT:
					if (burst_cnt == 0 && !cmd_full) begin
						cmd_en        <= 1'b1;
						cmd_instr     <= CMD_WRITE;
						cmd_byte_addr <= wr_ptr;
						wr_ptr        <= wr_ptr + ADDR_STEP;
					end
				S_RD_CMD:
					if (ob_room && !cmd_full) begin
						cmd_en        <= 1'b1;
						cmd_instr     <= CMD_READ;
						cmd_byte_addr <= rd_ptr;
						rd_ptr        <= rd_ptr + ADDR_STEP;
						burst_cnt     <= CNT_W'(BL);
					end
				S_RD_WAIT:
					if (!rd_empty)
						rd_en <= 1'b1;
				S_RD_POP:
					burst_cnt <= burst_cnt - 1'b1;
				// Words past the op count are popped and discarded
				S_RD_TAKE:
					if (!ops_done) begin
						ob_we    <= 1'b1;
						op_count <= op_count + op_step;
						ops_done <= ops_hit;
					end
				default: ;
			endcase
			if (addr_load) begin
				wr_ptr <= start_addr;
				rd_ptr <= start_addr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_WR_WAIT && ib_valid)
			wr_data <= ib_data;
		if (state == S_RD_TAKE && !ops_done)
			ob_data <= rd_data;
	end

endmodule

/* hdl/ddr_port.sv */
`timescale 1ns/100ps
`include "dma_cfg.svh"

module ddr_port import dma_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_d,
	input  logic                   cmd_en,
	input  mem_cmd_t               cmd_instr,
	input  logic [`DMA_ADDR_W-1:0] cmd_byte_addr,
	input  logic [5:0]             cmd_bl,
	output logic                   cmd_full,
	input  logic                   wr_en,
	input  logic [31:0]            wr_data,
	input  logic [3:0]             wr_mask,
	output logic                   wr_full,
	input  logic                   rd_en,
	output logic [31:0]            rd_data,
	output logic                   rd_empty,
	output logic                   calib_done
);

	localparam int AW = $clog2(`DMA_MEM_WORDS);
	localparam int CAL_W = $clog2(`DMA_CALIB_CYCLES + 1);

	localparam logic [2:0] P_IDLE   = 3'd0,
	                       P_FETCH  = 3'd1,
	                       P_WPOP   = 3'd2,
	                       P_WSTORE = 3'd3,
	                       P_READ   = 3'd4;

	logic [31:0]      mem [`DMA_MEM_WORDS];
	logic [2:0]       st;
	logic [CAL_W-1:0] calib_cnt;
	logic [5:0]       beat_cnt;
	logic [AW-1:0]    addr;
	logic [3:0]       burst_mask;
	logic [31:0]      cq_wdata;
	logic [31:0]      cq_rdata;
	logic             cq_re;
	logic             cq_rvalid;
	logic             cq_empty;
	logic [31:0]      wq_rdata;
	logic             wq_re;
	logic             wq_rvalid;
	logic             wq_empty;
	logic             rq_we;
	logic             rq_full;

	assign calib_done = (calib_cnt == CAL_W'(`DMA_CALIB_CYCLES));

	// Command word: instr, length, burst mask, word index
	assign cq_wdata = {cmd_instr, cmd_bl, wr_mask, (19 - AW)'(0), cmd_byte_addr[AW+1:2]};

	assign cq_re = (st == P_IDLE) && calib_done && !cq_empty;
	assign wq_re = (st == P_WPOP) && !wq_empty;
	assign rq_we = (st == P_READ) && !rq_full;

	sync_fifo #(.DEPTH(4)) u_cmd_q (
		.clk(clk), .reset_d(reset_d),
		.we(cmd_en), .wdata(cq_wdata),
		.re(cq_re), .rdata(cq_rdata), .rvalid(cq_rvalid),
		.count(), .full(cmd_full), .empty(cq_empty)
	);

	sync_fifo #(.DEPTH(32)) u_wr_q (
		.clk(clk), .reset_d(reset_d),
		.we(wr_en), .wdata(wr_data),
		.re(wq_re), .rdata(wq_rdata), .rvalid(wq_rvalid),
		.count(), .full(wr_full), .empty(wq_empty)
	);

	sync_fifo #(.DEPTH(32)) u_rd_q (
		.clk(clk), .reset_d(reset_d),
		.we(rq_we), .wdata(mem[addr]),
		.re(rd_en), .rdata(rd_data), .rvalid(),
		.count(), .full(rq_full), .empty(rd_empty)
	);

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			st         <= P_IDLE;
			calib_cnt  <= '0;
			beat_cnt   <= '0;
			addr       <= '0;
			burst_mask <= '0;
		end else begin
			if (!calib_done)
				calib_cnt <= calib_cnt + 1'b1;
			case (st)
				P_IDLE:
					if (cq_re)
						st <= P_FETCH;
				P_FETCH:
					if (cq_rvalid) begin
						beat_cnt   <= cq_rdata[28:23];
						burst_mask <= cq_rdata[22:19];
						addr       <= cq_rdata[AW-1:0];
						st <= (mem_cmd_t'(cq_rdata[31:29]) == CMD_READ) ? P_READ : P_WPOP;
					end
				P_WPOP:
					if (!wq_empty)
						st <= P_WSTORE;
				P_WSTORE:
					if (wq_rvalid) begin
						addr <= addr + 1'b1;
						beat_cnt <= beat_cnt - 1'b1;
						st <= (beat_cnt == 0) ? P_IDLE : P_WPOP;
					end
				P_READ:
					if (!rq_full) begin
						addr <= addr + 1'b1;
						beat_cnt <= beat_cnt - 1'b1;
						if (beat_cnt == 0)
							st <= P_IDLE;
					end
				default:
					st <= P_IDLE;
			endcase
		end
	end

	// Masked bytes keep their old contents
	always_ff @(posedge clk) begin
		if (st == P_WSTORE && wq_rvalid) begin
			for (int b = 0; b < 4; b++) begin
				if (!burst_mask[b])
					mem[addr][8*b +: 8] <= wq_rdata[8*b +: 8];
			end
		end
	end

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_top import dma_pkg::*; (
	input  logic        clk,
	input  logic        reset_d,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [4:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	input  logic        in_we,
	input  logic [31:0] in_data,
	output logic        in_full,
	input  logic        out_re,
	output logic [31:0] out_data,
	output logic        out_valid,
	output logic        out_empty
);

	localparam int CW = $clog2(`DMA_FIFO_DEPTH + 1);

	logic                   writes_en, reads_en, addr_load, busy, calib_done;
	logic [`DMA_ADDR_W-1:0] start_addr;
	logic [15:0]            op_num;
	op_type_t               op_type;
	logic                   ib_re, ib_valid, ob_we;
	logic [31:0]            ib_data, ob_data;
	logic [CW-1:0]          ib_count, ob_count;
	logic                   cmd_en, cmd_full, wr_en, wr_full, rd_en, rd_empty;
	mem_cmd_t               cmd_instr;
	logic [`DMA_ADDR_W-1:0] cmd_byte_addr;
	logic [5:0]             cmd_bl;
	logic [31:0]            wr_data, rd_data;
	logic [3:0]             wr_mask;

	dma_regs u_regs (
		.clk(clk), .reset_d(reset_d),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.calib_done(calib_done), .busy(busy),
		.writes_en(writes_en), .reads_en(reads_en), .start_addr(start_addr),
		.addr_load(addr_load), .op_num(op_num), .op_type(op_type)
	);

	// Input stream buffer
	sync_fifo #(.DEPTH(`DMA_FIFO_DEPTH)) u_in_buf (
		.clk(clk), .reset_d(reset_d), .we(in_we), .wdata(in_data),
		.re(ib_re), .rdata(ib_data), .rvalid(ib_valid),
		.count(ib_count), .full(in_full), .empty()
	);

	// Output stream buffer
	sync_fifo #(.DEPTH(`DMA_FIFO_DEPTH)) u_out_buf (
		.clk(clk), .reset_d(reset_d), .we(ob_we), .wdata(ob_data),
		.re(out_re), .rdata(out_data), .rvalid(out_valid),
		.count(ob_count), .full(), .empty(out_empty)
	);

	dma_engine u_engine (
		.clk(clk), .reset_d(reset_d),
		.writes_en(writes_en), .reads_en(reads_en), .calib_done(calib_done),
		.start_addr(start_addr), .addr_load(addr_load), .op_num(op_num), .op_type(op_type),
		.ib_re(ib_re), .ib_data(ib_data), .ib_count(ib_count), .ib_valid(ib_valid),
		.ob_we(ob_we), .ob_data(ob_data), .ob_count(ob_count),
		.cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_byte_addr(cmd_byte_addr),
		.cmd_bl(cmd_bl), .cmd_full(cmd_full),
		.wr_en(wr_en), .wr_data(wr_data), .wr_mask(wr_mask), .wr_full(wr_full),
		.rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty), .busy(busy)
	);

	ddr_port u_mem (
		.clk(clk), .reset_d(reset_d),
		.cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_byte_addr(cmd_byte_addr),
		.cmd_bl(cmd_bl), .cmd_full(cmd_full),
		.wr_en(wr_en), .wr_data(wr_data), .wr_mask(wr_mask), .wr_full(wr_full),
		.rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty),
		.calib_done(calib_done)
	);

endmodule

/* test/dma_tb.sv */
`timescale 1ns/100ps
`include "dma_cfg.svh"

module dma_tb import dma_pkg::*; ();

	localparam logic [4:0] REG_CONTROL = 5'h00;
	localparam logic [4:0] REG_START   = 5'h04;
	localparam logic [4:0] REG_OP_NUM  = 5'h08;
	localparam logic [4:0] REG_OP_TYPE = 5'h0c;
	localparam logic [4:0] REG_STATUS  = 5'h10;

	localparam int BL = `DMA_BURST_LEN;
	localparam int MEM_WORDS = `DMA_MEM_WORDS;
	localparam int WAIT_CYCLES = 2000;
	localparam int IDLE_POLLS = 10000;
	// Raw bursts restart while the output buffer holds fewer than OB_LIMIT words
	localparam int OB_LIMIT = `DMA_FIFO_DEPTH - 1 - BL;
	localparam int FILL_WORDS = BL * ((OB_LIMIT + BL - 1) / BL);

	logic        clk;
	logic        reset_d;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [4:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        in_we;
	logic [31:0] in_data;
	logic        in_full;
	logic        out_re;
	logic [31:0] out_data;
	logic        out_valid;
	logic        out_empty;

	logic [31:0] rng;
	// Expected memory contents, indexed by word address
	logic [31:0] model [MEM_WORDS];
	int          errors;

	dma_top DUT (
		.clk(clk), .reset_d(reset_d),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.in_we(in_we), .in_data(in_data), .in_full(in_full),
		.out_re(out_re), .out_data(out_data), .out_valid(out_valid), .out_empty(out_empty)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_with_failure();
		errors++;
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		stop_with_failure();
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %08h, actual %08h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %08h, actual %08h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_op_type(input string name, input op_type_t exp, input op_type_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic expect_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %0b, actual %0b", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > WAIT_CYCLES)
				report_timeout("a Wishbone write acknowledge");
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		do begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > WAIT_CYCLES)
				report_timeout("a Wishbone read acknowledge");
		end while (!wb_ack);
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// Random words into the input buffer, recorded at their target addresses
	task automatic push_words(input int n, input int first_word);
		int waited;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (in_full) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited > WAIT_CYCLES)
					report_timeout("room in the input buffer");
			end
			rng = xorshift32(rng);
			in_we = 1'b1;
			in_data = rng;
			model[(first_word + i) % MEM_WORDS] = rng;
			@(posedge clk);
			#1;
			in_we = 1'b0;
		end
	endtask

	task automatic pull_words(input string name, input int n, input int first_word);
		int waited;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (out_empty) begin
				@(posedge clk);
				#1;
				waited++;
				if (waited > WAIT_CYCLES)
					report_timeout($sformatf("output word %0d of %s", i, name));
			end
			out_re = 1'b1;
			waited = 0;
			do begin
				@(posedge clk);
				#1;
				out_re = 1'b0;
				waited++;
				if (waited > WAIT_CYCLES)
					report_timeout("output buffer read data");
			end while (!out_valid);
			check_word($sformatf("%s word %0d", name, i),
				model[(first_word + i) % MEM_WORDS], out_data);
		end
	endtask

	task automatic wait_calib();
		logic [31:0] s;
		int polls;
		polls = 0;
		s = '0;
		while (!s[0]) begin
			wb_read(REG_STATUS, s);
			polls++;
			if (polls > IDLE_POLLS)
				report_timeout("memory calibration");
		end
	endtask

	// A single idle cycle between bursts must not count as done
	task automatic wait_idle(input string name);
		logic [31:0] s;
		int quiet;
		int polls;
		quiet = 0;
		polls = 0;
		while (quiet < 3) begin
			wb_read(REG_STATUS, s);
			polls++;
			if (s[1])
				quiet = 0;
			else
				quiet++;
			if (polls > IDLE_POLLS)
				report_timeout($sformatf("the engine to go idle in %s", name));
		end
	endtask

	task automatic wait_output(input string name);
		int waited;
		waited = 0;
		while (out_empty) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > WAIT_CYCLES)
				report_timeout($sformatf("output data in %s", name));
		end
	endtask

	// Engine latches the read, so reads_en only needs a short pulse
	task automatic trigger_read();
		wb_write(REG_CONTROL, 32'h2);
		wb_write(REG_CONTROL, 32'h0);
	endtask

	task automatic register_access();
		logic [31:0] d;
		push_words(BL, 0);
		wb_write(REG_CONTROL, 32'h1);
		// Still inside the warm-up, a full burst waits in the buffer
		wb_read(REG_STATUS, d);
		check_reg("status before calibration", 32'h0, d);
		expect_flag("in_full before calibration", 1'b0, in_full);
		expect_flag("out_empty before calibration", 1'b1, out_empty);
		wait_calib();
		wait_idle("first write burst");
		// Words held through the warm-up reach memory intact
		wb_write(REG_CONTROL, 32'h0);
		wb_write(REG_START, 32'h0);
		trigger_read();
		pull_words("held burst", BL, 0);
		wait_idle("held burst readback");
		wb_write(REG_START, 32'h40);
		wb_write(REG_OP_NUM, 32'h1234);
		wb_write(REG_OP_TYPE, 32'(OP_CONV3));
		wb_write(REG_CONTROL, 32'h1);
		wb_read(REG_START, d);
		check_reg("start_addr readback", 32'h40, d);
		wb_read(REG_OP_NUM, d);
		check_reg("op_num readback", 32'h1234, d);
		wb_read(REG_OP_TYPE, d);
		check_op_type("op_type readback", OP_CONV3, op_type_t'(d[2:0]));
		wb_read(REG_CONTROL, d);
		check_reg("control readback", 32'h1, d);
		wb_read(REG_STATUS, d);
		check_reg("status after calibration", 32'h1, d);
		wb_write(REG_CONTROL, 32'h0);
	endtask

	task automatic raw_round_trip();
		wb_write(REG_OP_TYPE, 32'(OP_RAW));
		wb_write(REG_START, 32'h100);
		push_words(2 * BL, 32'h100 / 4);
		wb_write(REG_CONTROL, 32'h1);
		wait_idle("raw write");
		wb_write(REG_CONTROL, 32'h0);
		wb_write(REG_START, 32'h100);
		trigger_read();
		pull_words("raw round trip", BL, 32'h100 / 4);
		wait_idle("raw read");
		expect_flag("raw round trip extra words", 1'b1, out_empty);
	endtask

	task automatic conv_count();
		wb_write(REG_OP_TYPE, 32'(OP_CONV1));
		wb_write(REG_OP_NUM, 32'd32);
		wb_write(REG_START, 32'h100);
		trigger_read();
		pull_words("conv count", 32 * `DMA_CONV_BURST_LEN / BL, 32'h100 / 4);
		wait_idle("conv read");
		expect_flag("conv count extra words", 1'b1, out_empty);
	endtask

	task automatic pool_count();
		wb_write(REG_OP_TYPE, 32'(OP_POOL1));
		wb_write(REG_OP_NUM, 32'd32);
		wb_write(REG_START, 32'h100);
		trigger_read();
		pull_words("pool count", 32 * `DMA_POOL_BURST_LEN / BL, 32'h100 / 4);
		wait_idle("pool read");
		expect_flag("pool count extra words", 1'b1, out_empty);
	endtask

	task automatic back_pressure();
		// Fill the whole memory so every word read back is known
		wb_write(REG_OP_TYPE, 32'(OP_RAW));
		wb_write(REG_START, 32'h0);
		wb_write(REG_CONTROL, 32'h1);
		push_words(MEM_WORDS, 0);
		wait_idle("memory fill");
		wb_write(REG_CONTROL, 32'h0);
		wb_write(REG_START, 32'h0);
		wb_write(REG_CONTROL, 32'h2);
		wait_output("back-pressure");
		wait_idle("back-pressure fill");
		wb_write(REG_CONTROL, 32'h0);
		pull_words("back-pressure", FILL_WORDS, 0);
		expect_flag("back-pressure extra words", 1'b1, out_empty);
	endtask

	initial begin
		errors = 0;
		rng = 32'h75cf;
		reset_d = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		in_we = 1'b0;
		in_data = '0;
		out_re = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset_d = 1'b0;
		register_access();
		raw_round_trip();
		conv_count();
		pool_count();
		back_pressure();
		if (errors == 0) begin
			$display("No errors");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

/* tb.f */
+incdir+common
common/dma_pkg.sv
hdl/sync_fifo.sv
dma/dma_regs.sv
dma/dma_engine.sv
hdl/ddr_port.sv
hdl/dma_top.sv
test/dma_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= dma_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
